//--- include/axi_read_macros.svh
//////////////////////////////////////////////////////////////////////
// axi read slave parameters
// bus widths, beat step and output queue depth
//////////////////////////////////////////////////////////////////////

`ifndef AXI_READ_MACROS_SVH
`define AXI_READ_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////
`define AXI_ADDR_W 32
`define MEM_ADDR_W 32
`define AXI_DATA_W 64
`define AXI_ID_W   16
`define AXI_USER_W 10
`define AXI_LEN_W  8

//////////////////////////////////////////////////////////////////////
// burst and buffering
//////////////////////////////////////////////////////////////////////
// address step per beat, one full 64-bit word
`define BEAT_BYTES 8

`define RBUF_DEPTH 2   // beats reserved or held in the R queue

`endif

//--- source/axi_read_pkg.sv
//////////////////////////////////////////////////////////////////////
// axi read slave types
// width typedefs and the burst sequencer state encoding
//////////////////////////////////////////////////////////////////////

`include "axi_read_macros.svh"

package axi_read_pkg;

    typedef logic [`AXI_ADDR_W-1:0] addr_t;     // axi byte address
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t; // memory side address
    typedef logic [`AXI_DATA_W-1:0] data_t;
    typedef logic [`AXI_ID_W-1:0]   id_t;
    typedef logic [`AXI_USER_W-1:0] user_t;

    // burst length minus one, as on ARLEN
    typedef logic [`AXI_LEN_W-1:0]  len_t;

    // sequencer only waits for a request or issues beats
    typedef enum logic
    {
        SEQ_IDLE,
        SEQ_ISSUE
    } seq_state_t;

endpackage

//--- source/ar_request_reg.sv
//////////////////////////////////////////////////////////////////////
// ar request register
// holds one accepted AR request until the sequencer takes it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ar_request_reg
(
    input  logic                  clk,
    input  logic                  rst_n,

    // AR channel
    input  axi_read_pkg::id_t     ar_id_i,
    input  axi_read_pkg::addr_t   ar_addr_i,
    input  axi_read_pkg::len_t    ar_len_i,
    input  axi_read_pkg::user_t   ar_user_i,
    input  logic                  ar_valid_i,
    output logic                  ar_ready_o,

    // towards the sequencer
    input  logic                  req_take_i,
    output logic                  req_valid_o,
    output axi_read_pkg::id_t     req_id_o,
    output axi_read_pkg::addr_t   req_addr_o,
    output axi_read_pkg::len_t    req_len_o,
    output axi_read_pkg::user_t   req_user_o
);

    logic full_q;
    logic accept;

    assign ar_ready_o  = ~full_q;   // free slot, take the next burst
    assign accept      = ar_valid_i & ar_ready_o;
    assign req_valid_o = full_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            full_q <= 1'b0;
        else if (accept)
            full_q <= 1'b1;
        else if (req_take_i)
            full_q <= 1'b0;
    end

    // request fields only change on acceptance
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_id_o   <= ar_id_i;
            req_addr_o <= ar_addr_i;
            req_len_o  <= ar_len_i;
            req_user_o <= ar_user_i;
        end
    end

endmodule

//--- source/burst_sequencer.sv
//////////////////////////////////////////////////////////////////////
// burst sequencer
// walks an INCR burst and issues one memory request per beat
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "axi_read_macros.svh"

module burst_sequencer
(
    input  logic                      clk,
    input  logic                      rst_n,

    // request from the AR register
    input  logic                      req_valid_i,
    input  axi_read_pkg::id_t         req_id_i,
    input  axi_read_pkg::addr_t       req_addr_i,
    input  axi_read_pkg::len_t        req_len_i,
    input  axi_read_pkg::user_t       req_user_i,
    output logic                      req_take_o,

    // buffer space
    input  logic                      credit_i,

    // memory request side
    input  logic                      mem_grant_i,
    output logic                      mem_req_o,
    output axi_read_pkg::mem_addr_t   mem_addr_o,

    // beat tag towards the R buffer
    output logic                      beat_issue_o,
    output axi_read_pkg::id_t         beat_id_o,
    output axi_read_pkg::user_t       beat_user_o,
    output logic                      beat_last_o
);

    axi_read_pkg::seq_state_t state_q;
    axi_read_pkg::len_t       beat_cnt_q;
    axi_read_pkg::len_t       len_q;
    axi_read_pkg::id_t        id_q;
    axi_read_pkg::user_t      user_q;
    axi_read_pkg::mem_addr_t  addr_q;

    logic issue;
    logic last_beat;

    //////////////////////////////////////////////////////////////////////
    // handshakes
    //////////////////////////////////////////////////////////////////////
    assign req_take_o = (state_q == axi_read_pkg::SEQ_IDLE) & req_valid_i;

    // only ask while the buffer can reserve an entry
    assign mem_req_o  = (state_q == axi_read_pkg::SEQ_ISSUE) & credit_i;
    assign mem_addr_o = addr_q;

    assign issue     = mem_req_o & mem_grant_i;
    assign last_beat = (beat_cnt_q == len_q);

    assign beat_issue_o = issue;
    assign beat_last_o  = issue & last_beat;
    assign beat_id_o    = id_q;
    assign beat_user_o  = user_q;

    //////////////////////////////////////////////////////////////////////
    // state and beat counter
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q    <= axi_read_pkg::SEQ_IDLE;
            beat_cnt_q <= '0;
        end
        else
        begin
            case (state_q)
                axi_read_pkg::SEQ_IDLE:
                begin
                    if (req_take_o)
                    begin
                        state_q    <= axi_read_pkg::SEQ_ISSUE;
                        beat_cnt_q <= '0;
                    end
                end
                axi_read_pkg::SEQ_ISSUE:
                begin
                    if (issue)
                    begin
                        beat_cnt_q <= beat_cnt_q + axi_read_pkg::len_t'(1);
                        if (last_beat)
                            state_q <= axi_read_pkg::SEQ_IDLE; // burst fully issued
                    end
                end
                default:
                    state_q <= axi_read_pkg::SEQ_IDLE;
            endcase
        end
    end

    // burst context and running address
    always_ff @(posedge clk)
    begin
        if (req_take_o)
        begin
            id_q   <= req_id_i;
            user_q <= req_user_i;
            len_q  <= req_len_i;
            addr_q <= req_addr_i[`MEM_ADDR_W-1:0];
        end
        else if (issue)
        begin
            addr_q <= addr_q + axi_read_pkg::mem_addr_t'(`BEAT_BYTES);
        end
    end

endmodule

//--- source/r_beat_buffer.sv
//////////////////////////////////////////////////////////////////////
// R beat buffer
// in-order queue pairing beat tags with memory data, drives R
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "axi_read_macros.svh"

module r_beat_buffer
(
    input  logic                  clk,
    input  logic                  rst_n,

    // beat tags from the sequencer
    input  logic                  beat_issue_i,
    input  axi_read_pkg::id_t     beat_id_i,
    input  axi_read_pkg::user_t   beat_user_i,
    input  logic                  beat_last_i,
    output logic                  credit_o,

    // memory return
    input  logic                  mem_rvalid_i,
    input  axi_read_pkg::data_t   mem_rdata_i,

    // R channel
    input  logic                  r_ready_i,
    output logic                  r_valid_o,
    output axi_read_pkg::data_t   r_data_o,
    output axi_read_pkg::id_t     r_id_o,
    output axi_read_pkg::user_t   r_user_o,
    output logic                  r_last_o
);

    localparam int PTR_W = (`RBUF_DEPTH > 1) ? $clog2(`RBUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(`RBUF_DEPTH + 1);

    axi_read_pkg::id_t   id_q   [`RBUF_DEPTH];
    axi_read_pkg::user_t user_q [`RBUF_DEPTH];
    axi_read_pkg::data_t data_q [`RBUF_DEPTH];
    logic                last_q [`RBUF_DEPTH];
    logic [`RBUF_DEPTH-1:0] present_q;   // data arrived for the entry

    logic [PTR_W-1:0] res_ptr_q;
    logic [PTR_W-1:0] fill_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;      // reserved plus held entries

    logic pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(`RBUF_DEPTH - 1))
            return '0;
        return p + PTR_W'(1);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // R side
    //////////////////////////////////////////////////////////////////////
    assign r_valid_o = present_q[rd_ptr_q];  // head waits for its data
    assign r_data_o  = data_q[rd_ptr_q];
    assign r_id_o    = id_q[rd_ptr_q];
    assign r_user_o  = user_q[rd_ptr_q];
    assign r_last_o  = last_q[rd_ptr_q];

    assign pop      = r_valid_o & r_ready_i;
    assign credit_o = (count_q < CNT_W'(`RBUF_DEPTH));

    //////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            res_ptr_q  <= '0;
            fill_ptr_q <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            present_q  <= '0;
        end
        else
        begin
            if (beat_issue_i)
                res_ptr_q <= next_ptr(res_ptr_q);
            if (mem_rvalid_i)
            begin
                fill_ptr_q <= next_ptr(fill_ptr_q);
                present_q[fill_ptr_q] <= 1'b1;
            end
            if (pop)
            begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
                present_q[rd_ptr_q] <= 1'b0;
            end

            // one in, one out leaves the count alone
            if (beat_issue_i && !pop)
                count_q <= count_q + CNT_W'(1);
            else if (pop && !beat_issue_i)
                count_q <= count_q - CNT_W'(1);
        end
    end

    // entry contents
    always_ff @(posedge clk)
    begin
        if (beat_issue_i)
        begin
            id_q[res_ptr_q]   <= beat_id_i;
            user_q[res_ptr_q] <= beat_user_i;
            last_q[res_ptr_q] <= beat_last_i;
        end
        if (mem_rvalid_i)
            data_q[fill_ptr_q] <= mem_rdata_i; // returns follow grant order
    end

endmodule

//--- source/axi_mem_read_top.sv
//////////////////////////////////////////////////////////////////////
// axi memory read slave
// AR register, burst sequencer and R buffer in front of a memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module axi_mem_read_top
(
    input  logic                      clk,
    input  logic                      rst_n,

    // AR channel
    input  axi_read_pkg::id_t         ar_id_i,
    input  axi_read_pkg::addr_t       ar_addr_i,
    input  axi_read_pkg::len_t        ar_len_i,
    input  axi_read_pkg::user_t       ar_user_i,
    input  logic                      ar_valid_i,
    output logic                      ar_ready_o,

    // R channel
    output logic                      r_valid_o,
    output axi_read_pkg::data_t       r_data_o,
    output axi_read_pkg::id_t         r_id_o,
    output axi_read_pkg::user_t       r_user_o,
    output logic                      r_last_o,
    input  logic                      r_ready_i,

    // memory port
    output logic                      mem_req_o,
    output axi_read_pkg::mem_addr_t   mem_addr_o,
    input  logic                      mem_grant_i,
    input  logic                      mem_rvalid_i,
    input  axi_read_pkg::data_t       mem_rdata_i
);

    logic                req_valid;
    logic                req_take;
    axi_read_pkg::id_t   req_id;
    axi_read_pkg::addr_t req_addr;
    axi_read_pkg::len_t  req_len;
    axi_read_pkg::user_t req_user;

    logic                beat_issue;
    axi_read_pkg::id_t   beat_id;
    axi_read_pkg::user_t beat_user;
    logic                beat_last;
    logic                credit;

    ar_request_reg ar_request_reg_i
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .ar_id_i     (ar_id_i),
        .ar_addr_i   (ar_addr_i),
        .ar_len_i    (ar_len_i),
        .ar_user_i   (ar_user_i),
        .ar_valid_i  (ar_valid_i),
        .ar_ready_o  (ar_ready_o),
        .req_take_i  (req_take),
        .req_valid_o (req_valid),
        .req_id_o    (req_id),
        .req_addr_o  (req_addr),
        .req_len_o   (req_len),
        .req_user_o  (req_user)
    );

    burst_sequencer burst_sequencer_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid),
        .req_id_i     (req_id),
        .req_addr_i   (req_addr),
        .req_len_i    (req_len),
        .req_user_i   (req_user),
        .req_take_o   (req_take),
        .credit_i     (credit),
        .mem_grant_i  (mem_grant_i),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .beat_issue_o (beat_issue),
        .beat_id_o    (beat_id),
        .beat_user_o  (beat_user),
        .beat_last_o  (beat_last)
    );

    r_beat_buffer r_beat_buffer_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat_issue_i (beat_issue),
        .beat_id_i    (beat_id),
        .beat_user_i  (beat_user),
        .beat_last_i  (beat_last),
        .credit_o     (credit),
        .mem_rvalid_i (mem_rvalid_i),
        .mem_rdata_i  (mem_rdata_i),
        .r_ready_i    (r_ready_i),
        .r_valid_o    (r_valid_o),
        .r_data_o     (r_data_o),
        .r_id_o       (r_id_o),
        .r_user_o     (r_user_o),
        .r_last_o     (r_last_o)
    );

endmodule

//--- verif/tb_mem_model.sv
//////////////////////////////////////////////////////////////////////
// memory responder for the read slave testbench
// random grant, in-order return after 1 to 3 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_mem_model
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mem_req_i,
    input  axi_read_pkg::mem_addr_t mem_addr_i,
    output logic                    mem_grant_o,
    output logic                    mem_rvalid_o,
    output axi_read_pkg::data_t     mem_rdata_o
);

    axi_read_pkg::mem_addr_t addr_q[$];   // granted, not yet returned
    int                      due_q[$];
    int                      cyc = 0;

    initial
    begin
        mem_grant_o  = 1'b0;
        mem_rvalid_o = 1'b0;
        mem_rdata_o  = '0;
    end

    always @(posedge clk)
    begin
        if (rst_n && mem_req_i && mem_grant_o)
        begin
            addr_q.push_back(mem_addr_i);
            due_q.push_back(cyc + int'($urandom_range(3, 1)));
        end
        cyc = cyc + 1;
    end

    always @(negedge clk)
    begin
        axi_read_pkg::mem_addr_t addr;
        mem_grant_o  = rst_n && ($urandom_range(99) < 70);
        mem_rvalid_o = 1'b0;
        if (rst_n && due_q.size() > 0 && due_q[0] <= cyc)
        begin
            addr         = addr_q.pop_front();
            void'(due_q.pop_front());
            mem_rvalid_o = 1'b1;
            mem_rdata_o  = {~addr, addr};   // upper half inverted address
        end
    end

endmodule

//--- verif/tb_axi_mem_read.sv
//////////////////////////////////////////////////////////////////////
// axi read slave testbench
// replays read bursts from a pattern file and checks every R beat
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "axi_read_macros.svh"

module tb_axi_mem_read;

    logic                    clk = 1'b0;
    logic                    rst_n;
    axi_read_pkg::id_t       ar_id;
    axi_read_pkg::addr_t     ar_addr;
    axi_read_pkg::len_t      ar_len;
    axi_read_pkg::user_t     ar_user;
    logic                    ar_valid;
    logic                    ar_ready;
    logic                    r_valid;
    axi_read_pkg::data_t     r_data;
    axi_read_pkg::id_t       r_id;
    axi_read_pkg::user_t     r_user;
    logic                    r_last;
    logic                    r_ready;
    logic                    mem_req;
    axi_read_pkg::mem_addr_t mem_addr;
    logic                    mem_grant;
    logic                    mem_rvalid;
    axi_read_pkg::data_t     mem_rdata;

    // one entry per pattern line
    axi_read_pkg::id_t   pat_id[$];
    axi_read_pkg::user_t pat_user[$];
    axi_read_pkg::addr_t pat_addr[$];
    axi_read_pkg::len_t  pat_len[$];
    int                  pat_stall[$];

    int limit_cycles = 0;
    int pending = 0;    // issued beats not yet taken on R

    always #4 clk = ~clk;

    axi_mem_read_top axi_mem_read_top_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .ar_id_i      (ar_id),
        .ar_addr_i    (ar_addr),
        .ar_len_i     (ar_len),
        .ar_user_i    (ar_user),
        .ar_valid_i   (ar_valid),
        .ar_ready_o   (ar_ready),
        .r_valid_o    (r_valid),
        .r_data_o     (r_data),
        .r_id_o       (r_id),
        .r_user_o     (r_user),
        .r_last_o     (r_last),
        .r_ready_i    (r_ready),
        .mem_req_o    (mem_req),
        .mem_addr_o   (mem_addr),
        .mem_grant_i  (mem_grant),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata)
    );

    tb_mem_model mem_model_i
    (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_req_i    (mem_req),
        .mem_addr_i   (mem_addr),
        .mem_grant_o  (mem_grant),
        .mem_rvalid_o (mem_rvalid),
        .mem_rdata_o  (mem_rdata)
    );

    //////////////////////////////////////////////////////////////////////
    // reporting and compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_data(input string name, input axi_read_pkg::data_t got,
                              input axi_read_pkg::data_t exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_id(input string name, input axi_read_pkg::id_t got,
                            input axi_read_pkg::id_t exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_user(input string name, input axi_read_pkg::user_t got,
                              input axi_read_pkg::user_t exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus and R checking
    //////////////////////////////////////////////////////////////////////
    task automatic drive_requests();
        for (int i = 0; i < pat_id.size(); i++)
        begin
            @(negedge clk);
            ar_id    = pat_id[i];
            ar_user  = pat_user[i];
            ar_addr  = pat_addr[i];
            ar_len   = pat_len[i];
            ar_valid = 1'b1;
            @(posedge clk);
            while (!ar_ready)
                @(posedge clk);
        end
        @(negedge clk);
        ar_valid = 1'b0;
    endtask

    task automatic consume_beats();
        axi_read_pkg::addr_t addr;
        bit                  taken;
        for (int i = 0; i < pat_id.size(); i++)
        begin
            for (int k = 0; k <= pat_len[i]; k++)
            begin
                addr  = pat_addr[i] + axi_read_pkg::addr_t'(k * `BEAT_BYTES);
                taken = 1'b0;
                while (!taken)
                begin
                    @(negedge clk);
                    r_ready = ($urandom_range(99) >= pat_stall[i]);
                    @(posedge clk);
                    taken = r_valid && r_ready;
                end
                // memory returns ~addr in the upper half
                check_data("r_data_o", r_data, {~addr, addr});
                check_id("r_id_o", r_id, pat_id[i]);
                check_user("r_user_o", r_user, pat_user[i]);
                check_bit("r_last_o", r_last, k == pat_len[i]);
            end
        end
        @(negedge clk);
        r_ready = 1'b0;
    endtask

    // no memory request while every queue entry is taken
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (pending >= `RBUF_DEPTH && mem_req)
                fail_run("mem_req_o was raised while the R buffer was full");
            pending = pending + int'(mem_req && mem_grant) - int'(r_valid && r_ready);
        end
    end

    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles)
            @(posedge clk);
        fail_run($sformatf("timeout, the bursts did not complete within %0d cycles",
                           limit_cycles));
    end

    initial
    begin
        int                  fd;
        int                  stall;
        string               line;
        axi_read_pkg::id_t   id;
        axi_read_pkg::user_t user;
        axi_read_pkg::addr_t addr;
        axi_read_pkg::len_t  len;

        void'($urandom(15));
        rst_n    = 1'b0;
        ar_valid = 1'b0;
        ar_id    = '0;
        ar_addr  = '0;
        ar_len   = '0;
        ar_user  = '0;
        r_ready  = 1'b0;

        fd = $fopen("verif/read_patterns.txt", "r");
        if (fd == 0)
            fail_run("could not open the pattern file verif/read_patterns.txt");
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                if ($sscanf(line, "%h %h %h %h %d", id, user, addr, len, stall) != 5)
                    fail_run($sformatf("malformed pattern line: %s", line));
                pat_id.push_back(id);
                pat_user.push_back(user);
                pat_addr.push_back(addr);
                pat_len.push_back(len);
                pat_stall.push_back(stall);
            end
        end
        $fclose(fd);
        if (pat_id.size() == 0)
            fail_run("the pattern file holds no bursts");
        limit_cycles = 400 * pat_id.size() + 100;

        repeat (4)
            @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("ar_ready_o", ar_ready, 1'b1);
        check_bit("r_valid_o", r_valid, 1'b0);
        check_bit("mem_req_o", mem_req, 1'b0);

        fork
            drive_requests();
            consume_beats();
        join

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- verif/read_patterns.txt
# columns: id user start_addr len (all hex), stall (decimal percent of cycles with r_ready low)
# one burst per line, bursts are issued back to back in file order
0001 001 00001000 00 0
0002 002 00002000 0f 0
0003 003 00003000 07 90
0004 004 00003040 0f 90
00a1 0a1 00004000 03 20
00a2 0a2 00004100 03 20
00a3 0a3 00004200 03 20
0bee 3ff 00010f80 ff 0
1234 155 fffffff0 01 50
ffff 000 80000008 02 30

//--- sources.f
+incdir+include
source/axi_read_pkg.sv
source/ar_request_reg.sv
source/burst_sequencer.sv
source/r_beat_buffer.sv
source/axi_mem_read_top.sv
verif/tb_mem_model.sv
verif/tb_axi_mem_read.sv

//--- Bender.yml
package:
  name: axi_mem_read

sources:
  - include_dirs:
      - include
    files:
      - source/axi_read_pkg.sv
      - source/ar_request_reg.sv
      - source/burst_sequencer.sv
      - source/r_beat_buffer.sv
      - source/axi_mem_read_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_mem_model.sv
      - verif/tb_axi_mem_read.sv
